// File: dv/rf_protected_checks.sv
module rf_protected_checks #(
  parameter int NUM_READ_PORTS = rf_cfg_pkg::RF_NUM_READ_PORTS_DEFAULT
) (
  input  logic                 clk,
  input  logic                 check_en_i,
  input  logic [127:0]         test_name_i,

  // DUT outputs next to the model's expectations
  input  rf_cfg_pkg::rf_data_t rdata_i     [NUM_READ_PORTS],
  input  rf_cfg_pkg::rf_data_t exp_rdata_i [NUM_READ_PORTS],
  input  logic                 ecc_err_i,
  input  logic                 exp_err_i,
  input  logic                 ecc_fatal_i,
  input  logic                 exp_fatal_i,

  output logic                 failed_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [NUM_READ_PORTS-1:0] data_fail;
  logic                      err_fail   = 1'b0;
  logic                      fatal_fail = 1'b0;

  // One line per mismatch, values as sampled at the edge
  function automatic string error_line(
    input string       check,
    input logic [31:0] expected,
    input logic [31:0] actual
  );
    return $sformatf("** Error: test %0s, check %0s, expected 0x%08h, actual 0x%08h",
                     test_name_i, check, expected, actual);
  endfunction

  ////////////////////
  // Read data
  ////////////////////

  for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_port
    logic port_fail = 1'b0;

    assign data_fail[p] = port_fail;

    // Combinational read, includes flipped data bits
    read_data_ok: assert property (@(posedge clk) check_en_i |-> rdata_i[p] == exp_rdata_i[p])
      else begin
        $display("%s", error_line($sformatf("read_data_ok[%0d]", p),
                                  $sampled(exp_rdata_i[p]), $sampled(rdata_i[p])));
        port_fail = 1'b1;
      end
  end

  ////////////////////
  // Alarm outputs
  ////////////////////

  // Pulse one cycle after a faulty read
  err_pulse_ok: assert property (@(posedge clk) check_en_i |-> ecc_err_i == exp_err_i)
    else begin
      $display("%s", error_line("err_pulse_ok", {31'b0, $sampled(exp_err_i)},
                                {31'b0, $sampled(ecc_err_i)}));
      err_fail = 1'b1;
    end

  // Sticky until reset
  fatal_flag_ok: assert property (@(posedge clk) check_en_i |-> ecc_fatal_i == exp_fatal_i)
    else begin
      $display("%s", error_line("fatal_flag_ok", {31'b0, $sampled(exp_fatal_i)},
                                {31'b0, $sampled(ecc_fatal_i)}));
      fatal_fail = 1'b1;
    end

  assign failed_o = (|data_fail) | err_fail | fatal_fail;

endmodule

// File: dv/rf_protected_tb.sv
module rf_protected_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NRP          = rf_cfg_pkg::RF_NUM_READ_PORTS_DEFAULT;
  localparam int NWP          = rf_cfg_pkg::RF_NUM_WRITE_PORTS_DEFAULT;
  localparam int NREGS        = rf_cfg_pkg::RF_NUM_REGS;
  localparam int FLAG_TIMEOUT = 8;

  logic                 clk;
  logic                 reset_i;
  rf_cfg_pkg::rf_addr_t raddr [NRP];
  rf_cfg_pkg::rf_data_t rdata [NRP];
  rf_cfg_pkg::rf_addr_t waddr [NWP];
  rf_cfg_pkg::rf_data_t wdata [NWP];
  logic                 we    [NWP];
  logic                 inject;
  rf_cfg_pkg::rf_addr_t inject_addr;
  rf_ecc_pkg::rf_code_t inject_mask;
  logic                 ecc_err;
  logic                 ecc_fatal;

  // Model data per register and the bits flipped since the last write
  rf_cfg_pkg::rf_data_t model_data [NREGS];
  rf_ecc_pkg::rf_code_t model_flip [NREGS];
  rf_cfg_pkg::rf_data_t exp_rdata  [NRP];
  logic                 exp_err;
  logic                 exp_fatal;
  logic                 pend_err;
  logic                 pend_multi;
  logic                 check_en;
  logic                 check_failed;
  logic [127:0]         test_name;
  logic [31:0]          rng;
  rf_cfg_pkg::rf_addr_t addr;
  int                   bit_a;
  int                   bit_b;

  always #20 clk = ~clk;

  rf_protected UUT (
    .clk           ( clk         ),
    .reset_i       ( reset_i     ),
    .raddr_i       ( raddr       ),
    .rdata_o       ( rdata       ),
    .waddr_i       ( waddr       ),
    .wdata_i       ( wdata       ),
    .we_i          ( we          ),
    .inject_i      ( inject      ),
    .inject_addr_i ( inject_addr ),
    .inject_mask_i ( inject_mask ),
    .ecc_err_o     ( ecc_err     ),
    .ecc_fatal_o   ( ecc_fatal   )
  );

  rf_protected_checks checks_i (
    .clk         ( clk          ),
    .check_en_i  ( check_en     ),
    .test_name_i ( test_name    ),
    .rdata_i     ( rdata        ),
    .exp_rdata_i ( exp_rdata    ),
    .ecc_err_i   ( ecc_err      ),
    .exp_err_i   ( exp_err      ),
    .ecc_fatal_i ( ecc_fatal    ),
    .exp_fatal_i ( exp_fatal    ),
    .failed_o    ( check_failed )
  );

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge check_failed) stop_with_failure("A DUT output differed from the model");

  // xorshift32 with its state in rng
  function automatic logic [31:0] draw_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Right-aligned ASCII for the error lines
  function automatic logic [127:0] pack_name(input string s);
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < s.len() && i < 16; i++) v = {v[119:0], s[i]};
    return v;
  endfunction

  ////////////////////
  // Model
  ////////////////////

  // Inputs of the cycle that just ended as the rising edge saw them
  task automatic commit_model();
    logic hit;
    if (reset_i) begin
      for (int r = 0; r < NREGS; r++) begin
        model_data[r] = '0;
        model_flip[r] = '0;
      end
      exp_err   = 1'b0;
      exp_fatal = 1'b0;
    end else begin
      for (int r = 1; r < NREGS; r++) begin
        hit = 1'b0;
        // Later port overrides
        // A write also clears old flips
        for (int w = 0; w < NWP; w++) begin
          if (we[w] && waddr[w] == rf_cfg_pkg::rf_addr_t'(r)) begin
            model_data[r] = wdata[w];
            model_flip[r] = '0;
            hit           = 1'b1;
          end
        end
        if (!hit && inject && inject_addr == rf_cfg_pkg::rf_addr_t'(r)) begin
          model_flip[r] = model_flip[r] ^ inject_mask;
        end
      end
      exp_err   = pend_err;
      exp_fatal = exp_fatal | pend_multi;
    end
  endtask

  // Expected read data and the alarm due one cycle later
  task automatic predict_reads();
    int flips;
    pend_err   = 1'b0;
    pend_multi = 1'b0;
    for (int p = 0; p < NRP; p++) begin
      flips        = $countones(model_flip[raddr[p]]);
      exp_rdata[p] = model_data[raddr[p]] ^ model_flip[raddr[p]][31:0];
      // Odd count is single and even nonzero count is multi
      if (flips % 2 == 1) begin
        pend_err = 1'b1;
      end else if (flips != 0) begin
        pend_err   = 1'b1;
        pend_multi = 1'b1;
      end
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // Falling edge, model update, then idle inputs
  task automatic begin_cycle();
    @(negedge clk);
    commit_model();
    check_en = 1'b1;
    inject   = 1'b0;
    for (int w = 0; w < NWP; w++) we[w] = 1'b0;
    for (int p = 0; p < NRP; p++) raddr[p] = '0;
  endtask

  task automatic random_reads();
    for (int p = 0; p < NRP; p++) raddr[p] = rf_cfg_pkg::rf_addr_t'(draw_random());
  endtask

  // Expects reset_i already high
  task automatic run_reset();
    for (int c = 0; c < 8; c++) begin
      begin_cycle();
      if (c == 7) reset_i = 1'b0;
      random_reads();
      predict_reads();
    end
  endtask

  task automatic wait_for_flag(input logic want_fatal, input string what);
    int n;
    n = 0;
    while (!(want_fatal ? ecc_fatal : ecc_err)) begin
      if (n == FLAG_TIMEOUT) stop_with_failure({"Timeout: ", what});
      begin_cycle();
      predict_reads();
      n++;
    end
  endtask

  initial begin
    clk         = 1'b0;
    reset_i     = 1'b1;
    inject      = 1'b0;
    inject_addr = '0;
    inject_mask = '0;
    check_en    = 1'b0;
    exp_err     = 1'b0;
    exp_fatal   = 1'b0;
    pend_err    = 1'b0;
    pend_multi  = 1'b0;
    rng         = 32'd65365;
    for (int w = 0; w < NWP; w++) begin
      we[w]    = 1'b0;
      waddr[w] = '0;
      wdata[w] = '0;
    end
    for (int p = 0; p < NRP; p++) raddr[p] = '0;

    // Reset state during and after reset
    test_name = pack_name("reset");
    run_reset();
    repeat (3) begin
      begin_cycle();
      random_reads();
      predict_reads();
    end

    // Random traffic where port 1 often reads the address port 0 writes
    test_name = pack_name("random_rw");
    for (int c = 0; c < 200; c++) begin
      begin_cycle();
      for (int w = 0; w < NWP; w++) begin
        we[w]    = draw_random() > 32'h7fff_ffff;
        waddr[w] = rf_cfg_pkg::rf_addr_t'(draw_random());
        wdata[w] = draw_random();
      end
      random_reads();
      if (c % 2 == 0) raddr[1] = waddr[0];
      predict_reads();
    end

    // Same address on both write ports
    test_name = pack_name("write_conflict");
    addr      = rf_cfg_pkg::rf_addr_t'(draw_random() % 31 + 1);
    begin_cycle();
    we       = '{NWP{1'b1}};
    waddr    = '{NWP{addr}};
    wdata[0] = draw_random();
    wdata[1] = ~wdata[0];
    predict_reads();
    begin_cycle();
    raddr[0] = addr;
    predict_reads();

    // One flipped bit and then a rewrite
    test_name = pack_name("single_fault");
    addr      = rf_cfg_pkg::rf_addr_t'(draw_random() % 31 + 1);
    begin_cycle();
    we[0]    = 1'b1;
    waddr[0] = addr;
    wdata[0] = draw_random();
    predict_reads();
    begin_cycle();
    inject      = 1'b1;
    inject_addr = addr;
    inject_mask = rf_ecc_pkg::rf_code_t'(1) << (draw_random() % 39);
    predict_reads();
    begin_cycle();
    raddr[0] = addr;
    predict_reads();
    wait_for_flag(1'b0, "ecc_err_o did not pulse after a single-bit fault");
    begin_cycle();
    we[1]    = 1'b1;
    waddr[1] = addr;
    wdata[1] = draw_random();
    predict_reads();
    repeat (2) begin
      begin_cycle();
      raddr[1] = addr;
      predict_reads();
    end

    // Two flipped bits with fatal holding through clean reads
    test_name = pack_name("double_fault");
    addr      = rf_cfg_pkg::rf_addr_t'(draw_random() % 31 + 1);
    bit_a     = int'(draw_random() % 39);
    bit_b     = (bit_a + 1 + int'(draw_random() % 38)) % 39;
    begin_cycle();
    inject      = 1'b1;
    inject_addr = addr;
    inject_mask = (rf_ecc_pkg::rf_code_t'(1) << bit_a) | (rf_ecc_pkg::rf_code_t'(1) << bit_b);
    predict_reads();
    begin_cycle();
    raddr[1] = addr;
    predict_reads();
    wait_for_flag(1'b1, "ecc_fatal_o did not rise after a double-bit fault");
    begin_cycle();
    we[0]    = 1'b1;
    waddr[0] = addr;
    wdata[0] = draw_random();
    predict_reads();
    repeat (4) begin
      begin_cycle();
      random_reads();
      predict_reads();
    end

    // A new reset is the only way out of fatal
    test_name = pack_name("fatal_reset");
    begin_cycle();
    reset_i = 1'b1;
    predict_reads();
    run_reset();
    repeat (3) begin
      begin_cycle();
      random_reads();
      predict_reads();
    end

    // Last reads and their alarm still need two rising edges
    repeat (2) begin
      begin_cycle();
      predict_reads();
    end

    if (check_failed !== 1'b1) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      stop_with_failure("A DUT output differed from the model");
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module rf_protected_tb \
  -Mdir obj_dir -o rf_protected_sim -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rf_protected_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: sim.f
source/rf_cfg_pkg.sv
source/rf_ecc_pkg.sv
source/rf_ecc_encoder.sv
source/rf_storage.sv
source/rf_ecc_checker.sv
source/rf_ecc_alarm.sv
source/rf_protected.sv
dv/rf_protected_checks.sv
dv/rf_protected_tb.sv

// File: source/rf_cfg_pkg.sv
package rf_cfg_pkg;

  ////////////////////
  // Geometry
  ////////////////////

  // 32 integer registers, x0 hardwired to zero
  localparam int RF_NUM_REGS   = 32;
  localparam int RF_ADDR_WIDTH = 5;
  localparam int RF_DATA_WIDTH = 32;

  // Register index as seen on every port
  typedef logic [RF_ADDR_WIDTH-1:0] rf_addr_t;

  // Architectural data word, without check bits
  typedef logic [RF_DATA_WIDTH-1:0] rf_data_t;

  ////////////////////
  // Port counts
  ////////////////////

  // Two operand reads per instruction
  localparam int RF_NUM_READ_PORTS_DEFAULT  = 2;

  // Writeback plus one spare port
  localparam int RF_NUM_WRITE_PORTS_DEFAULT = 2;

endpackage

// File: source/rf_ecc_alarm.sv
module rf_ecc_alarm #(
  parameter int NUM_READ_PORTS = rf_cfg_pkg::RF_NUM_READ_PORTS_DEFAULT
) (
  input  logic                    clk,
  input  logic                    reset_i,

  // One status per checker
  input  rf_ecc_pkg::ecc_status_e port_status_i [NUM_READ_PORTS],

  // Towards the core alert logic
  output logic                    ecc_err_o,
  output logic                    ecc_fatal_o
);

  logic any_err;
  logic any_multi;

  // OR over all read ports
  always_comb begin
    any_err   = 1'b0;
    any_multi = 1'b0;
    for (int p = 0; p < NUM_READ_PORTS; p++) begin
      any_err   = any_err | (port_status_i[p] != rf_ecc_pkg::ECC_OK);
      any_multi = any_multi | (port_status_i[p] == rf_ecc_pkg::ECC_MULTI);
    end
  end

  // Pulse per faulty cycle, fatal holds until reset
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ecc_err_o   <= 1'b0;
      ecc_fatal_o <= 1'b0;
    end else begin
      ecc_err_o   <= any_err;
      ecc_fatal_o <= ecc_fatal_o | any_multi;
    end
  end

endmodule

// File: source/rf_ecc_checker.sv
module rf_ecc_checker (
  // Stored word from one read port
  input  rf_ecc_pkg::rf_code_t    code_rdata_i,

  // Data as stored, never corrected
  output rf_cfg_pkg::rf_data_t    rdata_o,
  output rf_ecc_pkg::ecc_status_e status_o
);

  localparam int DW = rf_cfg_pkg::RF_DATA_WIDTH;
  localparam int CW = rf_ecc_pkg::ECC_CHECK_WIDTH;
  localparam int HW = CW - 1;

  rf_cfg_pkg::rf_data_t data;
  logic [HW-1:0]        stored_ham;
  logic                 stored_par;
  logic [CW-1:0]        calc_chk;
  logic [HW-1:0]        syndrome;
  logic                 parity_err;

  ////////////////////
  // Field split
  ////////////////////

  assign data       = code_rdata_i[DW-1:0];
  assign stored_ham = code_rdata_i[DW +: HW];
  assign stored_par = code_rdata_i[rf_ecc_pkg::ECC_WORD_WIDTH-1];

  // Recompute from the data part only
  assign calc_chk = rf_ecc_pkg::ecc_check_bits(data);

  // Nonzero points at the flipped position
  assign syndrome = calc_chk[HW-1:0] ^ stored_ham;

  // Parity of the whole 39 bits, rewritten through calc_chk
  // calc_chk[HW] already covers data and recomputed Hamming bits
  assign parity_err = stored_par ^ calc_chk[HW] ^ (^syndrome);

  ////////////////////
  // Classification
  ////////////////////

  always_comb begin
    if (parity_err) begin
      // Odd flip count, taken as single
      status_o = rf_ecc_pkg::ECC_SINGLE;
    end else if (syndrome != '0) begin
      // Even flip count with damage
      status_o = rf_ecc_pkg::ECC_MULTI;
    end else begin
      status_o = rf_ecc_pkg::ECC_OK;
    end
  end

  assign rdata_o = data;

endmodule

// File: source/rf_ecc_encoder.sv
module rf_ecc_encoder #(
  parameter int NUM_WRITE_PORTS = rf_cfg_pkg::RF_NUM_WRITE_PORTS_DEFAULT
) (
  // Raw write data from the core
  input  rf_cfg_pkg::rf_data_t wdata_i      [NUM_WRITE_PORTS],

  // Protected words towards the storage
  output rf_ecc_pkg::rf_code_t code_wdata_o [NUM_WRITE_PORTS]
);

  ////////////////////
  // Per-port encode
  ////////////////////

  for (genvar w = 0; w < NUM_WRITE_PORTS; w++) begin : g_enc
    // Check bits of this port
    logic [rf_ecc_pkg::ECC_CHECK_WIDTH-1:0] check;

    assign check = rf_ecc_pkg::ecc_check_bits(wdata_i[w]);

    // Check bits on top, data passes unchanged below
    assign code_wdata_o[w] = {check, wdata_i[w]};
  end

endmodule

// File: source/rf_ecc_pkg.sv
package rf_ecc_pkg;

  ////////////////////
  // Code word layout
  ////////////////////

  // 6 Hamming bits plus overall parity on top
  localparam int ECC_CHECK_WIDTH = 7;
  localparam int ECC_WORD_WIDTH  = rf_cfg_pkg::RF_DATA_WIDTH + ECC_CHECK_WIDTH;

  // Data in [31:0], Hamming in [37:32], overall parity in [38]
  typedef logic [ECC_WORD_WIDTH-1:0] rf_code_t;

  // Per-port read classification
  typedef enum logic [1:0] {
    ECC_OK     = 2'b00,
    ECC_SINGLE = 2'b01,
    ECC_MULTI  = 2'b10
  } ecc_status_e;

  ////////////////////
  // Check bits
  ////////////////////

  // Data bits take the non power-of-two positions 3,5,6,7,9 and so on
  // Hamming bit j covers every position with bit j set
  function automatic logic [ECC_CHECK_WIDTH-1:0] ecc_check_bits(
    input rf_cfg_pkg::rf_data_t data
  );
    logic [ECC_CHECK_WIDTH-1:0] chk;
    int unsigned                di;
    chk = '0;
    di  = 0;
    for (int unsigned pos = 1; pos < ECC_WORD_WIDTH; pos++) begin
      // Skip slots that hold a Hamming bit
      if ((pos & (pos - 1)) != 0) begin
        for (int unsigned j = 0; j < ECC_CHECK_WIDTH - 1; j++) begin
          if (pos[j]) chk[j] = chk[j] ^ data[di];
        end
        di++;
      end
    end
    // Overall parity over data and Hamming bits
    chk[ECC_CHECK_WIDTH-1] = ^{data, chk[ECC_CHECK_WIDTH-2:0]};
    return chk;
  endfunction

endpackage

// File: source/rf_protected.sv
module rf_protected #(
  parameter int NUM_READ_PORTS  = rf_cfg_pkg::RF_NUM_READ_PORTS_DEFAULT,
  parameter int NUM_WRITE_PORTS = rf_cfg_pkg::RF_NUM_WRITE_PORTS_DEFAULT
) (
  // Clock and reset
  input  logic                 clk,
  input  logic                 reset_i,

  // Read ports
  input  rf_cfg_pkg::rf_addr_t raddr_i [NUM_READ_PORTS],
  output rf_cfg_pkg::rf_data_t rdata_o [NUM_READ_PORTS],

  // Write ports
  input  rf_cfg_pkg::rf_addr_t waddr_i [NUM_WRITE_PORTS],
  input  rf_cfg_pkg::rf_data_t wdata_i [NUM_WRITE_PORTS],
  input  logic                 we_i    [NUM_WRITE_PORTS],

  // Fault injection hook
  input  logic                 inject_i,
  input  rf_cfg_pkg::rf_addr_t inject_addr_i,
  input  rf_ecc_pkg::rf_code_t inject_mask_i,

  // Error reporting
  output logic                 ecc_err_o,
  output logic                 ecc_fatal_o
);

  // Encoded words between the blocks
  rf_ecc_pkg::rf_code_t    code_wdata  [NUM_WRITE_PORTS];
  rf_ecc_pkg::rf_code_t    code_rdata  [NUM_READ_PORTS];
  rf_ecc_pkg::ecc_status_e port_status [NUM_READ_PORTS];

  ////////////////////
  // Write path
  ////////////////////

  rf_ecc_encoder #(
    .NUM_WRITE_PORTS ( NUM_WRITE_PORTS )
  ) encoder_i (
    .wdata_i      ( wdata_i    ),
    .code_wdata_o ( code_wdata )
  );

  rf_storage #(
    .NUM_READ_PORTS  ( NUM_READ_PORTS  ),
    .NUM_WRITE_PORTS ( NUM_WRITE_PORTS )
  ) storage_i (
    .clk           ( clk           ),
    .reset_i       ( reset_i       ),
    .waddr_i       ( waddr_i       ),
    .code_wdata_i  ( code_wdata    ),
    .we_i          ( we_i          ),
    .inject_i      ( inject_i      ),
    .inject_addr_i ( inject_addr_i ),
    .inject_mask_i ( inject_mask_i ),
    .raddr_i       ( raddr_i       ),
    .code_rdata_o  ( code_rdata    )
  );

  ////////////////////
  // Read path
  ////////////////////

  // One checker per read port
  for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_check
    rf_ecc_checker checker_i (
      .code_rdata_i ( code_rdata[p]  ),
      .rdata_o      ( rdata_o[p]     ),
      .status_o     ( port_status[p] )
    );
  end

  rf_ecc_alarm #(
    .NUM_READ_PORTS ( NUM_READ_PORTS )
  ) alarm_i (
    .clk           ( clk         ),
    .reset_i       ( reset_i     ),
    .port_status_i ( port_status ),
    .ecc_err_o     ( ecc_err_o   ),
    .ecc_fatal_o   ( ecc_fatal_o )
  );

endmodule

// File: source/rf_storage.sv
module rf_storage #(
  parameter int NUM_READ_PORTS  = rf_cfg_pkg::RF_NUM_READ_PORTS_DEFAULT,
  parameter int NUM_WRITE_PORTS = rf_cfg_pkg::RF_NUM_WRITE_PORTS_DEFAULT
) (
  input  logic                 clk,
  input  logic                 reset_i,

  // Write ports, already encoded
  input  rf_cfg_pkg::rf_addr_t waddr_i      [NUM_WRITE_PORTS],
  input  rf_ecc_pkg::rf_code_t code_wdata_i [NUM_WRITE_PORTS],
  input  logic                 we_i         [NUM_WRITE_PORTS],

  // Fault injection, verification only
  input  logic                 inject_i,
  input  rf_cfg_pkg::rf_addr_t inject_addr_i,
  input  rf_ecc_pkg::rf_code_t inject_mask_i,

  // Read ports
  input  rf_cfg_pkg::rf_addr_t raddr_i      [NUM_READ_PORTS],
  output rf_ecc_pkg::rf_code_t code_rdata_o [NUM_READ_PORTS]
);

  localparam int NUM_REGS = rf_cfg_pkg::RF_NUM_REGS;

  // x0 has no storage
  rf_ecc_pkg::rf_code_t mem_q [1:NUM_REGS-1];

  ////////////////////
  // Register update
  ////////////////////

  for (genvar r = 1; r < NUM_REGS; r++) begin : g_reg
    rf_ecc_pkg::rf_code_t wr_code;
    logic                 wr_hit;
    logic                 inj_hit;

    // Port order scan, last matching port overrides
    always_comb begin
      wr_hit  = 1'b0;
      wr_code = mem_q[r];
      for (int w = 0; w < NUM_WRITE_PORTS; w++) begin
        if (we_i[w] && (waddr_i[w] == rf_cfg_pkg::rf_addr_t'(r))) begin
          wr_hit  = 1'b1;
          wr_code = code_wdata_i[w];
        end
      end
    end

    assign inj_hit = inject_i && (inject_addr_i == rf_cfg_pkg::rf_addr_t'(r));

    // All-zero data has all-zero check bits, so '0 is a valid word
    always_ff @(posedge clk) begin
      if (reset_i) begin
        mem_q[r] <= '0;
      end else if (wr_hit) begin
        mem_q[r] <= wr_code;
      end else if (inj_hit) begin
        // Flip stored bits only when no write lands here
        mem_q[r] <= mem_q[r] ^ inject_mask_i;
      end
    end
  end

  ////////////////////
  // Read muxes
  ////////////////////

  for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_rd
    // x0 returns the constant zero code word
    assign code_rdata_o[p] = (raddr_i[p] == '0) ? '0 : mem_q[raddr_i[p]];
  end

endmodule
